// File: rvc_expander_top.f
rvc_pkg.sv
rvc_fifo.sv
rvc_quadrant0.sv
rvc_quadrant1.sv
rvc_quadrant2.sv
rvc_ctrl.sv
rvc_expander_top.sv
tb_rvc_clk.sv
tb_rvc_expander.sv

// File: Makefile
# Verilator build of the RV32C expander testbench

SIM := obj_dir/Vtb_rvc_expander

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module tb_rvc_expander -f rvc_expander_top.f

run: compile
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

// File: tb_rvc_expander.sv
// ----------------------------
// testbench for the RV32C expander stage
// credited fetch and decoder models around the DUT, a reference
// expansion of every sent word and an in-order compare of the outputs
// ----------------------------
`default_nettype none

module tb_rvc_expander;

  localparam int unsigned NUM_RANDOM   = 200;
  localparam int unsigned NUM_DIRECTED = 43;

  // one half per kept instruction and per illegal rule, by quadrant
  localparam rvc_pkg::chalf_t DIRECTED [NUM_DIRECTED] = '{
    16'h0040, 16'h0000, 16'h4124, 16'hDD24, 16'h2000, 16'h6000, 16'h8000, 16'hA000,
    16'hE000, 16'h0001, 16'h12FD, 16'h3FFD, 16'h451D, 16'h6185, 16'h6181, 16'h717D,
    16'h6101, 16'h800D, 16'h84FD, 16'h9979, 16'h8C05, 16'h8C25, 16'h8C45, 16'h8C65,
    16'h9C05, 16'hA0A5, 16'hBFFD, 16'hCC61, 16'hF37D, 16'h0292, 16'h50FE, 16'h4002,
    16'h8082, 16'h8002, 16'h829A, 16'h9002, 16'h9282, 16'h929A, 16'hDF9E, 16'h2002,
    16'h6002, 16'hA002, 16'hE002
  };

  logic              clk;
  logic              rst_n;
  logic              in_valid;
  rvc_pkg::instr_t   in_word;
  logic              in_credit;
  logic              out_valid;
  rvc_pkg::decoded_t out_insn;
  logic              out_credit;

  rvc_pkg::instr_t   words[$];
  rvc_pkg::decoded_t expected[$];
  int unsigned       due[$];
  logic [15:0]       lfsr;
  int unsigned       cycle          = 0;
  int unsigned       sent           = 0;
  int unsigned       fetch_credits  = rvc_pkg::FIFO_DEPTH;
  int unsigned       in_credit_seen = 0;
  int unsigned       out_seen       = 0;
  int unsigned       credits_back   = 0;

  tb_rvc_clk u_clk (.clk_o(clk), .rst_n_o(rst_n));

  rvc_expander_top u_dut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .in_valid_i   (in_valid),
    .in_word_i    (in_word),
    .in_credit_o  (in_credit),
    .out_valid_o  (out_valid),
    .out_insn_o   (out_insn),
    .out_credit_i (out_credit)
  );

  // ----------------------------
  // random bits, 16-bit LFSR with taps 16 14 13 11
  // ----------------------------
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // ----------------------------
  // RV32 encoders, immediates come in as plain values
  // ----------------------------
  function automatic rvc_pkg::instr_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic rvc_pkg::instr_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rvc_pkg::OPC_OP};
  endfunction

  function automatic rvc_pkg::instr_t enc_store(input logic [11:0] imm, input logic [4:0] rs2,
                                                input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvc_pkg::OPC_STORE};
  endfunction

  function automatic rvc_pkg::instr_t enc_b(input logic [12:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3);
    return {imm[12], imm[10:5], rvc_pkg::REG_ZERO, rs1, f3, imm[4:1], imm[11],
            rvc_pkg::OPC_BRANCH};
  endfunction

  function automatic rvc_pkg::instr_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvc_pkg::OPC_JAL};
  endfunction

  // expected decoder word for one fetch word
  function automatic rvc_pkg::decoded_t ref_expand(input rvc_pkg::instr_t w);
    rvc_pkg::decoded_t d;
    logic [15:0] c;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  creg_hi;
    logic [4:0]  creg_lo;
    logic [31:0] imm;
    logic        bad;
    c       = w[15:0];
    f3      = c[15:13];
    rd      = c[11:7];
    rs2     = c[6:2];
    creg_hi = 5'd8 + 5'(c[9:7]);
    creg_lo = 5'd8 + 5'(c[4:2]);
    imm     = '0;
    bad     = 1'b0;
    d       = '0;
    if (w[1:0] == 2'b11) begin
      d.insn = w;
      return d;
    end
    d.is_compressed = 1'b1;
    case (w[1:0])
      rvc_pkg::QUAD_C0: begin
        case (f3)
          3'b000: begin
            imm    = {22'b0, c[10:7], c[12:11], c[5], c[6], 2'b00};
            d.insn = enc_i(imm[11:0], rvc_pkg::REG_SP, 3'b000, creg_lo, rvc_pkg::OPC_OP_IMM);
            bad    = (imm == '0);
          end
          3'b010: begin
            imm    = {25'b0, c[5], c[12:10], c[6], 2'b00};
            d.insn = enc_i(imm[11:0], creg_hi, 3'b010, creg_lo, rvc_pkg::OPC_LOAD);
          end
          3'b110: begin
            imm    = {25'b0, c[5], c[12:10], c[6], 2'b00};
            d.insn = enc_store(imm[11:0], creg_lo, creg_hi);
          end
          default: bad = 1'b1;
        endcase
      end
      rvc_pkg::QUAD_C1: begin
        case (f3)
          3'b000, 3'b010: begin
            // c.addi adds to rd, c.li adds to x0
            imm    = {{26{c[12]}}, c[12], c[6:2]};
            d.insn = enc_i(imm[11:0], (f3 == 3'b000) ? rd : rvc_pkg::REG_ZERO, 3'b000, rd,
                           rvc_pkg::OPC_OP_IMM);
          end
          3'b001, 3'b101: begin
            imm    = {{21{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
            d.insn = enc_j(imm[20:0], (f3 == 3'b001) ? rvc_pkg::REG_RA : rvc_pkg::REG_ZERO);
          end
          3'b011: begin
            bad = ({c[12], c[6:2]} == 6'd0);
            if (rd == rvc_pkg::REG_SP) begin
              imm    = {{23{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000};
              d.insn = enc_i(imm[11:0], rvc_pkg::REG_SP, 3'b000, rvc_pkg::REG_SP,
                             rvc_pkg::OPC_OP_IMM);
            end else begin
              imm    = {{14{c[12]}}, c[12], c[6:2], 12'b0};
              d.insn = {imm[31:12], rd, rvc_pkg::OPC_LUI};
            end
          end
          3'b100: begin
            case (c[11:10])
              2'b00, 2'b01: begin
                d.insn = enc_i({1'b0, c[10], 4'b0000, c[12], c[6:2]}, creg_hi, 3'b101, creg_hi,
                               rvc_pkg::OPC_OP_IMM);
              end
              2'b10: begin
                d.insn = enc_i({{6{c[12]}}, c[12], c[6:2]}, creg_hi, 3'b111, creg_hi,
                               rvc_pkg::OPC_OP_IMM);
              end
              default: begin
                bad = c[12];
                case (c[6:5])
                  2'b00:   d.insn = enc_r(7'b0100000, creg_lo, creg_hi, 3'b000, creg_hi);
                  2'b01:   d.insn = enc_r(7'b0000000, creg_lo, creg_hi, 3'b100, creg_hi);
                  2'b10:   d.insn = enc_r(7'b0000000, creg_lo, creg_hi, 3'b110, creg_hi);
                  default: d.insn = enc_r(7'b0000000, creg_lo, creg_hi, 3'b111, creg_hi);
                endcase
              end
            endcase
          end
          default: begin
            imm    = {{24{c[12]}}, c[6:5], c[2], c[11:10], c[4:3], 1'b0};
            d.insn = enc_b(imm[12:0], creg_hi, (f3 == 3'b110) ? 3'b000 : 3'b001);
          end
        endcase
      end
      default: begin
        case (f3)
          3'b000: begin
            d.insn = enc_i({6'b0, c[12], c[6:2]}, rd, 3'b001, rd, rvc_pkg::OPC_OP_IMM);
          end
          3'b010: begin
            imm    = {24'b0, c[3:2], c[12], c[6:4], 2'b00};
            d.insn = enc_i(imm[11:0], rvc_pkg::REG_SP, 3'b010, rd, rvc_pkg::OPC_LOAD);
            bad    = (rd == rvc_pkg::REG_ZERO);
          end
          3'b100: begin
            if (rs2 != rvc_pkg::REG_ZERO) begin
              // c.mv reads x0, c.add reads rd
              d.insn = enc_r(7'b0, rs2, c[12] ? rd : rvc_pkg::REG_ZERO, 3'b000, rd);
            end else if (c[12] && rd == rvc_pkg::REG_ZERO) begin
              d.insn = rvc_pkg::EBREAK_WORD;
            end else begin
              d.insn = enc_i(12'd0, rd, 3'b000, c[12] ? rvc_pkg::REG_RA : rvc_pkg::REG_ZERO,
                             rvc_pkg::OPC_JALR);
              bad    = !c[12] && (rd == rvc_pkg::REG_ZERO);
            end
          end
          3'b110: begin
            imm    = {24'b0, c[8:7], c[12:9], 2'b00};
            d.insn = enc_store(imm[11:0], rs2, rvc_pkg::REG_SP);
          end
          default: bad = 1'b1;
        endcase
      end
    endcase
    if (bad) begin
      d.insn = w;
    end
    d.illegal = bad;
    return d;
  endfunction

  // ----------------------------
  // checks
  // ----------------------------
  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_insn(input rvc_pkg::decoded_t exp, input rvc_pkg::decoded_t act);
    if (act !== exp) begin
      report_failure($sformatf("ERROR time=%0t signal=out_insn_o expected=%h actual=%h",
                               $time, exp, act));
    end
  endtask

  task automatic check_count(input string name, input int unsigned exp,
                             input int unsigned act);
    if (act !== exp) begin
      report_failure($sformatf("ERROR time=%0t signal=%s expected=%0d actual=%0d",
                               $time, name, exp, act));
    end
  endtask

  // directed halves first, then random words
  task automatic build_words();
    logic [31:0] kind;
    logic [31:0] r;
    foreach (DIRECTED[i]) begin
      words.push_back({16'hA5A5, DIRECTED[i]});
    end
    words.push_back(32'h0000_0013);
    words.push_back(32'hFFFF_FFFF);
    for (int i = 0; i < NUM_RANDOM; i++) begin
      // low two bits pick quadrant 0..2 or a full word
      rand_bits(2, kind);
      rand_bits(32, r);
      words.push_back({r[31:2], kind[1:0]});
    end
  endtask

  // ----------------------------
  // fetch model, one word per credit
  // ----------------------------
  always @(posedge clk) begin
    if (rst_n) begin
      if (in_credit === 1'b1) begin
        fetch_credits++;
        in_credit_seen++;
      end
      if (fetch_credits > rvc_pkg::FIFO_DEPTH) begin
        report_failure("fetch credit returned for a word that was never sent");
      end else if (fetch_credits > 0 && sent < words.size()) begin
        in_valid <= 1'b1;
        in_word  <= words[sent];
        expected.push_back(ref_expand(words[sent]));
        fetch_credits--;
        sent++;
      end else begin
        in_valid <= 1'b0;
      end
    end
  end

  // decoder model, each credit comes back 0 to 7 cycles later
  always @(posedge clk) begin : credit_model
    logic [31:0] delay;
    int          due_idx;
    if (rst_n) begin
      cycle++;
      if (out_valid === 1'b1) begin
        rand_bits(3, delay);
        due.push_back(cycle + delay);
      end
      due_idx = -1;
      foreach (due[i]) begin
        if (due_idx < 0 && due[i] <= cycle) begin
          due_idx = i;
        end
      end
      if (due_idx >= 0) begin
        due.delete(due_idx);
        out_credit <= 1'b1;
      end else begin
        out_credit <= 1'b0;
      end
    end
  end

  // compare outputs in send order
  always @(posedge clk) begin
    if (!rst_n) begin
      if (out_valid !== 1'b0) begin
        report_failure("out_valid_o was not low during reset");
      end
    end else begin
      if (out_credit === 1'b1) begin
        credits_back++;
      end
      if (out_valid === 1'b1) begin
        out_seen++;
        if (expected.size() == 0) begin
          report_failure("an output appeared with no word pending");
        end else if (out_seen > credits_back + 32'(rvc_pkg::OUT_CREDITS)) begin
          report_failure("an output was sent without a downstream credit");
        end else begin
          check_insn(expected.pop_front(), out_insn);
        end
      end
    end
  end

  // watchdog, 20 cycles per word
  initial begin
    @(posedge rst_n);
    repeat (20 * words.size()) @(posedge clk);
    report_failure("timeout while waiting for the DUT outputs");
  end

  initial begin
    in_valid   <= 1'b0;
    in_word    <= '0;
    out_credit <= 1'b0;
    lfsr = 16'd44;
    build_words();
    @(posedge rst_n);
    while (sent < words.size() || expected.size() != 0) begin
      @(posedge clk);
    end
    // let the last credits come home
    repeat (12) @(posedge clk);
    check_count("in_credit_o pulses", sent, in_credit_seen);
    check_count("out_valid_o cycles", sent, out_seen);
    check_count("out_credit_i pulses", out_seen, credits_back);
    if (due.size() == 0 && fetch_credits == rvc_pkg::FIFO_DEPTH) begin
      $display("Everything OK");
      $finish;
    end else begin
      report_failure("credits were still outstanding at the end of the run");
    end
  end

endmodule

`default_nettype wire

// File: tb_rvc_clk.sv
// ----------------------------
// testbench clock and reset
// period of 4, reset low for the first 3 cycles
// ----------------------------
`default_nettype none

module tb_rvc_clk (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

// File: rvc_expander_top.sv
// ----------------------------
// RV32C expander stage, top level
// fetch words in through a credited queue, decoded words out
// to a credited decoder port
// ----------------------------
`default_nettype none

module rvc_expander_top (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              in_valid_i,
  input  rvc_pkg::instr_t   in_word_i,
  output logic              in_credit_o,
  output logic              out_valid_o,
  output rvc_pkg::decoded_t out_insn_o,
  input  logic              out_credit_i
);

  rvc_pkg::instr_t  head;
  logic             empty;
  logic             pop;
  rvc_pkg::chalf_t  half;
  rvc_pkg::expand_t q0_res;
  rvc_pkg::expand_t q1_res;
  rvc_pkg::expand_t q2_res;

  rvc_fifo #(
    .DEPTH (rvc_pkg::FIFO_DEPTH)
  ) u_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (in_valid_i),
    .data_i  (in_word_i),
    .pop_i   (pop),
    .data_o  (head),
    .empty_o (empty)
  );

  rvc_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .head_i       (head),
    .empty_i      (empty),
    .pop_o        (pop),
    .q0_i         (q0_res),
    .q1_i         (q1_res),
    .q2_i         (q2_res),
    .half_o       (half),
    .out_credit_i (out_credit_i),
    .out_valid_o  (out_valid_o),
    .out_insn_o   (out_insn_o),
    .in_credit_o  (in_credit_o)
  );

  // all three quadrants see the same half, ctrl picks one
  rvc_quadrant0 u_quad0 (.half_i(half), .res_o(q0_res));
  rvc_quadrant1 u_quad1 (.half_i(half), .res_o(q1_res));
  rvc_quadrant2 u_quad2 (.half_i(half), .res_o(q2_res));

endmodule

`default_nettype wire

// File: rvc_ctrl.sv
// ----------------------------
// expander control
// pops the queue when a downstream credit is free, picks the quadrant
// result and registers it, returns one fetch credit per popped word
// ----------------------------
`default_nettype none

module rvc_ctrl (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  rvc_pkg::instr_t   head_i,
  input  logic              empty_i,
  output logic              pop_o,
  input  rvc_pkg::expand_t  q0_i,
  input  rvc_pkg::expand_t  q1_i,
  input  rvc_pkg::expand_t  q2_i,
  output rvc_pkg::chalf_t   half_o,
  input  logic              out_credit_i,
  output logic              out_valid_o,
  output rvc_pkg::decoded_t out_insn_o,
  output logic              in_credit_o
);

  logic [rvc_pkg::CREDIT_W-1:0] credits;
  logic [rvc_pkg::CREDIT_W:0]   credit_sum;
  logic [rvc_pkg::CREDIT_W:0]   credit_owed;
  rvc_pkg::expand_t             sel;
  rvc_pkg::decoded_t            dec;

  assign half_o = head_i[15:0];

  // ----------------------------
  // downstream credits
  // ----------------------------
  // the word now in the output register still owes its credit,
  // a credit coming back this cycle is already usable
  assign credit_sum  = {1'b0, credits} + {{rvc_pkg::CREDIT_W{1'b0}}, out_credit_i};
  assign credit_owed = {{rvc_pkg::CREDIT_W{1'b0}}, out_valid_o};
  assign pop_o       = !empty_i && (credit_sum > credit_owed);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credits <= rvc_pkg::OUT_CREDITS;
    end else begin
      case ({out_credit_i, out_valid_o})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // ----------------------------
  // result select
  // ----------------------------
  always_comb begin
    unique case (head_i[1:0])
      rvc_pkg::QUAD_C0: sel = q0_i;
      rvc_pkg::QUAD_C1: sel = q1_i;
      rvc_pkg::QUAD_C2: sel = q2_i;
      default: begin
        // full 32-bit word passes through
        sel.insn    = head_i;
        sel.illegal = 1'b0;
      end
    endcase
  end

  always_comb begin
    dec.insn          = sel.illegal ? head_i : sel.insn;
    dec.is_compressed = (head_i[1:0] != 2'b11);
    dec.illegal       = sel.illegal;
  end

  // output register, the fetch credit goes back with the same pulse
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_o <= 1'b0;
      out_insn_o  <= '0;
    end else begin
      out_valid_o <= pop_o;
      if (pop_o) out_insn_o <= dec;
    end
  end

  assign in_credit_o = out_valid_o;

  // decoder returned more credits than it was given
  a_credit_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credits <= rvc_pkg::OUT_CREDITS);

endmodule

`default_nettype wire

// File: rvc_quadrant2.sv
// ----------------------------
// quadrant 2 expander, combinational
// c.slli, stack load and store, jump register, move and add
// ----------------------------
`default_nettype none

module rvc_quadrant2 (
  input  rvc_pkg::chalf_t  half_i,
  output rvc_pkg::expand_t res_o
);

  localparam logic [2:0] F3_SLLI      = 3'b000;
  localparam logic [2:0] F3_LWSP      = 3'b010;
  localparam logic [2:0] F3_JR_MV_ADD = 3'b100;
  localparam logic [2:0] F3_SWSP      = 3'b110;

  logic [4:0] rd;
  logic [4:0] rs2;

  assign rd  = half_i[11:7];
  assign rs2 = half_i[6:2];

  always_comb begin
    res_o.insn    = '0;
    res_o.illegal = 1'b0;
    unique case (half_i[15:13])
      F3_SLLI: begin
        res_o.insn = {6'b0, half_i[12], rs2, rd, 3'b001, rd, rvc_pkg::OPC_OP_IMM};
      end
      F3_LWSP: begin
        res_o.insn = {4'b0, half_i[3:2], half_i[12], half_i[6:4], 2'b00,
                      rvc_pkg::REG_SP, 3'b010, rd, rvc_pkg::OPC_LOAD};
        res_o.illegal = (rd == rvc_pkg::REG_ZERO);
      end
      F3_JR_MV_ADD: begin
        if (!half_i[12]) begin
          if (rs2 == rvc_pkg::REG_ZERO) begin
            // c.jr
            res_o.insn    = {12'b0, rd, 3'b000, rvc_pkg::REG_ZERO, rvc_pkg::OPC_JALR};
            res_o.illegal = (rd == rvc_pkg::REG_ZERO);
          end else begin
            // c.mv
            res_o.insn = {7'b0, rs2, rvc_pkg::REG_ZERO, 3'b000, rd, rvc_pkg::OPC_OP};
          end
        end else if (rs2 == rvc_pkg::REG_ZERO) begin
          if (rd == rvc_pkg::REG_ZERO) begin
            res_o.insn = rvc_pkg::EBREAK_WORD;
          end else begin
            // c.jalr links through ra
            res_o.insn = {12'b0, rd, 3'b000, rvc_pkg::REG_RA, rvc_pkg::OPC_JALR};
          end
        end else begin
          // c.add
          res_o.insn = {7'b0, rs2, rd, 3'b000, rd, rvc_pkg::OPC_OP};
        end
      end
      F3_SWSP: begin
        res_o.insn = {4'b0, half_i[8:7], half_i[12], rs2, rvc_pkg::REG_SP, 3'b010,
                      half_i[11:9], 2'b00, rvc_pkg::OPC_STORE};
      end
      // fp stack access, RV64 forms, Zcmp and Zcmt rows
      default: res_o.illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// File: rvc_quadrant1.sv
// ----------------------------
// quadrant 1 expander, combinational
// immediates, shifts, ALU group, jumps and branches
// ----------------------------
`default_nettype none

module rvc_quadrant1 (
  input  rvc_pkg::chalf_t  half_i,
  output rvc_pkg::expand_t res_o
);

  localparam logic [2:0] F3_ADDI = 3'b000;
  localparam logic [2:0] F3_JAL  = 3'b001;
  localparam logic [2:0] F3_LI   = 3'b010;
  localparam logic [2:0] F3_LUI  = 3'b011;
  localparam logic [2:0] F3_MISC = 3'b100;
  localparam logic [2:0] F3_J    = 3'b101;
  localparam logic [2:0] F3_BEQZ = 3'b110;
  localparam logic [2:0] F3_BNEZ = 3'b111;

  logic [4:0]  rd;
  logic [4:0]  rdp;
  logic [4:0]  rs2p;
  logic [11:0] imm6;
  logic [19:0] jimm;
  logic [2:0]  alu_f3;
  logic [6:0]  alu_f7;

  assign rd   = half_i[11:7];
  assign rdp  = {2'b01, half_i[9:7]};
  assign rs2p = {2'b01, half_i[4:2]};

  // sign extended 6-bit immediate shared by addi, li and andi
  assign imm6 = {{7{half_i[12]}}, half_i[6:2]};

  // J-type field order imm[20|10:1|11|19:12]
  assign jimm = {half_i[12], half_i[8], half_i[10:9], half_i[6], half_i[7],
                 half_i[2], half_i[11], half_i[5:3], {9{half_i[12]}}};

  // register-register row, bits 6:5 pick the operation
  always_comb begin
    alu_f7 = 7'b0000000;
    unique case (half_i[6:5])
      2'b00: begin
        alu_f3 = 3'b000;
        alu_f7 = 7'b0100000;
      end
      2'b01:   alu_f3 = 3'b100;
      2'b10:   alu_f3 = 3'b110;
      default: alu_f3 = 3'b111;
    endcase
  end

  always_comb begin
    res_o.insn    = '0;
    res_o.illegal = 1'b0;
    unique case (half_i[15:13])
      // c.nop is addi x0, x0, 0
      F3_ADDI: res_o.insn = {imm6, rd, 3'b000, rd, rvc_pkg::OPC_OP_IMM};
      F3_JAL:  res_o.insn = {jimm, rvc_pkg::REG_RA, rvc_pkg::OPC_JAL};
      F3_LI:   res_o.insn = {imm6, rvc_pkg::REG_ZERO, 3'b000, rd, rvc_pkg::OPC_OP_IMM};
      F3_LUI: begin
        if (rd == rvc_pkg::REG_SP) begin
          // c.addi16sp, immediate scaled by 16
          res_o.insn = {{3{half_i[12]}}, half_i[4:3], half_i[5], half_i[2], half_i[6],
                        4'b0000, rvc_pkg::REG_SP, 3'b000, rvc_pkg::REG_SP,
                        rvc_pkg::OPC_OP_IMM};
        end else begin
          res_o.insn = {{15{half_i[12]}}, half_i[6:2], rd, rvc_pkg::OPC_LUI};
        end
        res_o.illegal = ({half_i[12], half_i[6:2]} == 6'b000000);
      end
      F3_MISC: begin
        unique case (half_i[11:10])
          2'b00, 2'b01: begin
            // bit 10 selects srai
            res_o.insn = {1'b0, half_i[10], 4'b0000, half_i[12], half_i[6:2],
                          rdp, 3'b101, rdp, rvc_pkg::OPC_OP_IMM};
          end
          2'b10: res_o.insn = {imm6, rdp, 3'b111, rdp, rvc_pkg::OPC_OP_IMM};
          default: begin
            res_o.insn    = {alu_f7, rs2p, rdp, alu_f3, rdp, rvc_pkg::OPC_OP};
            // subw, addw and the Zcb forms
            res_o.illegal = half_i[12];
          end
        endcase
      end
      F3_J: res_o.insn = {jimm, rvc_pkg::REG_ZERO, rvc_pkg::OPC_JAL};
      F3_BEQZ, F3_BNEZ: begin
        // bit 13 turns beq into bne
        res_o.insn = {{4{half_i[12]}}, half_i[6:5], half_i[2], rvc_pkg::REG_ZERO, rdp,
                      2'b00, half_i[13], half_i[11:10], half_i[4:3], half_i[12],
                      rvc_pkg::OPC_BRANCH};
      end
      default: res_o.illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// File: rvc_quadrant0.sv
// ----------------------------
// quadrant 0 expander, combinational
// c.addi4spn, c.lw and c.sw, everything else is illegal
// ----------------------------
`default_nettype none

module rvc_quadrant0 (
  input  rvc_pkg::chalf_t  half_i,
  output rvc_pkg::expand_t res_o
);

  localparam logic [2:0] F3_ADDI4SPN = 3'b000;
  localparam logic [2:0] F3_LW       = 3'b010;
  localparam logic [2:0] F3_SW       = 3'b110;

  // compressed registers x8..x15
  logic [4:0] rdp;
  logic [4:0] rs1p;

  assign rdp  = {2'b01, half_i[4:2]};
  assign rs1p = {2'b01, half_i[9:7]};

  always_comb begin
    res_o.insn    = '0;
    res_o.illegal = 1'b0;
    unique case (half_i[15:13])
      F3_ADDI4SPN: begin
        // addi rd', x2, nzuimm
        res_o.insn = {2'b00, half_i[10:7], half_i[12:11], half_i[5], half_i[6], 2'b00,
                      rvc_pkg::REG_SP, 3'b000, rdp, rvc_pkg::OPC_OP_IMM};
        res_o.illegal = (half_i[12:5] == 8'h00);
      end
      F3_LW: begin
        res_o.insn = {5'b0, half_i[5], half_i[12:10], half_i[6], 2'b00,
                      rs1p, 3'b010, rdp, rvc_pkg::OPC_LOAD};
      end
      F3_SW: begin
        // rd' field holds rs2'
        res_o.insn = {5'b0, half_i[5], half_i[12], rdp, rs1p, 3'b010,
                      half_i[11:10], half_i[6], 2'b00, rvc_pkg::OPC_STORE};
      end
      // fp loads and stores, Zcb row and reserved
      default: res_o.illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// File: rvc_fifo.sv
// ----------------------------
// input queue for fetch words
// the upstream credit scheme guarantees a free slot for every push
// ----------------------------
`default_nettype none

module rvc_fifo #(
  parameter int unsigned DEPTH = rvc_pkg::FIFO_DEPTH
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            push_i,
  input  rvc_pkg::instr_t data_i,
  input  logic            pop_i,
  output rvc_pkg::instr_t data_o,
  output logic            empty_o
);

  localparam int unsigned AW = $clog2(DEPTH);
  localparam int unsigned CW = $clog2(DEPTH + 1);

  rvc_pkg::instr_t mem [DEPTH];
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic [CW-1:0]   count;
  logic            full;

  assign empty_o = (count == '0);
  assign full    = (count == CW'(DEPTH));
  assign data_o  = mem[rd_ptr];

  // pointers wrap on their own since DEPTH is a power of two
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) wr_ptr <= wr_ptr + 1'b1;
      if (pop_i) rd_ptr <= rd_ptr + 1'b1;
      unique case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) mem[wr_ptr] <= data_i;
  end

  // fetch unit pushed without a credit
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(push_i && full));

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(pop_i && empty_o));

endmodule

`default_nettype wire

// File: rvc_pkg.sv
// ----------------------------
// shared definitions for the RV32C expander stage
// opcodes, register numbers, queue and credit sizes, payload structs
// every file refers to these as rvc_pkg::name
// ----------------------------
`default_nettype none

package rvc_pkg;

  // ----------------------------
  // payload types
  // ----------------------------
  typedef logic [31:0] instr_t;
  typedef logic [15:0] chalf_t;

  // result of one quadrant expander
  typedef struct packed {
    instr_t insn;
    logic   illegal;
  } expand_t;

  // what the decoder receives
  typedef struct packed {
    instr_t insn;
    logic   is_compressed;
    logic   illegal;
  } decoded_t;

  // ----------------------------
  // RV32 major opcodes
  // ----------------------------
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  // compressed quadrants, 2'b11 marks a full 32-bit word
  localparam logic [1:0] QUAD_C0 = 2'b00;
  localparam logic [1:0] QUAD_C1 = 2'b01;
  localparam logic [1:0] QUAD_C2 = 2'b10;

  // fixed register numbers
  localparam logic [4:0] REG_ZERO = 5'd0;
  localparam logic [4:0] REG_RA   = 5'd1;
  localparam logic [4:0] REG_SP   = 5'd2;

  localparam instr_t EBREAK_WORD = 32'h0010_0073;

  // ----------------------------
  // flow control sizes
  // ----------------------------
  // queue depth, also the fetch unit's credits after reset
  localparam int unsigned FIFO_DEPTH = 4;

  // downstream credit counter
  localparam int unsigned CREDIT_W = 2;
  localparam logic [CREDIT_W-1:0] OUT_CREDITS = 2'd2;

endpackage

`default_nettype wire
